//--- Bender.yml
package:
  name: action_engine

sources:
  - action_pkg.sv
  - action_crossbar.sv
  - container_alu.sv
  - stateful_alu.sv
  - metadata_alu.sv
  - state_mem_arbiter.sv
  - action_engine.sv
  - target: simulation
    files:
      - action_engine_checker.sv
      - action_engine_tb.sv

//--- action_crossbar.sv
`timescale 1ns/1ps

module action_crossbar (
    input  logic                    clk,
    input  logic                    rst_n,
    input  action_pkg::phv_t        phv_i,
    input  action_pkg::action_t     action_i,
    input  logic                    phv_valid_i,
    input  logic                    ready_i,
    output logic                    ready_o,
    output logic                    adv_o,
    output logic                    valid_o,
    output action_pkg::container_t  op_a_o [4],
    output action_pkg::container_t  op_b_o [4],
    output action_pkg::sub_action_t sub_act_o [4],
    output action_pkg::meta_t       meta_o,
    output action_pkg::sub_action_t meta_act_o
);

    logic                   adv;
    logic                   valid_q;
    logic                   s2_full_q;
    action_pkg::phv_t       phv_q;
    action_pkg::action_t    act_q;
    action_pkg::container_t cont [4];

    // one enable for the whole pipe
    assign adv     = ready_i | ~s2_full_q;
    assign ready_o = adv;
    assign adv_o   = adv;
    assign valid_o = valid_q;

    // s2_full_q tracks the stage-two valid bit held in the stateful ALU
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            s2_full_q <= 1'b0;
        end else if (adv) begin
            valid_q   <= phv_valid_i;
            s2_full_q <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            phv_q <= phv_i;
            act_q <= action_i;
        end
    end

    // ======================================================================
    // operand selection, any container can feed any ALU
    // ======================================================================
    for (genvar i = 0; i < 4; i++) begin : g_sel
        assign cont[i]      = phv_q[32*i+32 +: 32];
        assign sub_act_o[i] = act_q[16*i+16 +: 16];
        assign op_a_o[i]    = cont[action_pkg::sub_src_a(sub_act_o[i])];
        assign op_b_o[i]    = cont[action_pkg::sub_src_b(sub_act_o[i])];
    end

    // metadata sits in the low word of both vectors
    assign meta_o     = phv_q[31:0];
    assign meta_act_o = act_q[15:0];

endmodule

//--- action_engine.sv
`timescale 1ns/1ps

module action_engine #(
    parameter int STATE_ADDR_W = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  action_pkg::phv_t        phv_i,
    input  action_pkg::action_t     action_i,
    input  logic                    phv_valid_i,
    input  logic                    ready_i,
    output logic                    ready_o,
    output action_pkg::phv_t        phv_o,
    output logic                    phv_valid_o,
    input  logic                    cfg_req_i,
    input  logic                    cfg_we_i,
    input  logic [STATE_ADDR_W-1:0] cfg_addr_i,
    input  action_pkg::container_t  cfg_wdata_i,
    output logic                    cfg_ack_o,
    output action_pkg::container_t  cfg_rdata_o
);

    logic                    adv;
    logic                    s1_valid;
    action_pkg::container_t  op_a [4];
    action_pkg::container_t  op_b [4];
    action_pkg::sub_action_t sub_act [4];
    action_pkg::meta_t       meta_s1;
    action_pkg::sub_action_t meta_act;
    action_pkg::container_t  result [4];
    action_pkg::meta_t       meta_res;
    logic [STATE_ADDR_W-1:0] st_addr;
    action_pkg::container_t  st_wdata;
    action_pkg::container_t  st_rdata;
    logic                    st_we;

    action_crossbar u_xbar (
        .clk(clk), .rst_n(rst_n),
        .phv_i(phv_i), .action_i(action_i), .phv_valid_i(phv_valid_i),
        .ready_i(ready_i), .ready_o(ready_o), .adv_o(adv), .valid_o(s1_valid),
        .op_a_o(op_a), .op_b_o(op_b), .sub_act_o(sub_act),
        .meta_o(meta_s1), .meta_act_o(meta_act)
    );

    // stateless containers 0 to 2
    for (genvar i = 0; i < 3; i++) begin : g_alu
        container_alu u_alu (
            .clk(clk), .rst_n(rst_n), .adv_i(adv),
            .op_a_i(op_a[i]), .op_b_i(op_b[i]), .sub_act_i(sub_act[i]),
            .result_o(result[i])
        );
    end

    stateful_alu #(.STATE_ADDR_W(STATE_ADDR_W)) u_st_alu (
        .clk(clk), .rst_n(rst_n), .adv_i(adv), .valid_i(s1_valid),
        .op_a_i(op_a[3]), .sub_act_i(sub_act[3]), .st_rdata_i(st_rdata),
        .result_o(result[3]), .valid_o(phv_valid_o),
        .st_addr_o(st_addr), .st_wdata_o(st_wdata), .st_we_o(st_we)
    );

    metadata_alu u_meta_alu (
        .clk(clk), .rst_n(rst_n), .adv_i(adv),
        .meta_i(meta_s1), .meta_act_i(meta_act), .meta_o(meta_res)
    );

    state_mem_arbiter #(.STATE_ADDR_W(STATE_ADDR_W)) u_arb (
        .clk(clk), .rst_n(rst_n),
        .st_addr_i(st_addr), .st_wdata_i(st_wdata), .st_we_i(st_we),
        .st_rdata_o(st_rdata),
        .cfg_req_i(cfg_req_i), .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_ack_o(cfg_ack_o), .cfg_rdata_o(cfg_rdata_o)
    );

    assign phv_o = {result[3], result[2], result[1], result[0], meta_res};

endmodule

//--- action_engine_checker.sv
`timescale 1ns/1ps

module action_engine_checker #(
    parameter int STATE_ADDR_W = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [2:0]              phase_i,
    input  action_pkg::phv_t        phv_i,
    input  action_pkg::action_t     action_i,
    input  logic                    phv_valid_i,
    input  logic                    ready_i,
    input  logic                    dut_ready_i,
    input  action_pkg::phv_t        out_phv_i,
    input  logic                    out_valid_i,
    input  logic                    cfg_req_i,
    input  logic                    cfg_we_i,
    input  logic [STATE_ADDR_W-1:0] cfg_addr_i,
    input  action_pkg::container_t  cfg_wdata_i,
    input  logic                    cfg_ack_i,
    input  action_pkg::container_t  cfg_rdata_i,
    output int                      pending_o,
    output int                      data_errs_o,
    output int                      cfg_errs_o,
    output int                      proto_errs_o
);

    localparam int DEPTH = 2 ** STATE_ADDR_W;

    action_pkg::container_t state_m [DEPTH];
    action_pkg::phv_t       exp_q [$];
    logic [2:0]             phase_q [$];
    action_pkg::phv_t       held_phv;
    action_pkg::phv_t       exp_phv;
    logic [2:0]             exp_phase;
    logic                   rst_seen;
    logic                   first_acc;
    logic                   stalled;

    function automatic string phase_name(input logic [2:0] p);
        case (p)
            3'd2:    return "stateless";
            3'd3:    return "metadata";
            3'd4:    return "stateful";
            3'd5:    return "backpressure";
            3'd6:    return "control";
            default: return "reset";
        endcase
    endfunction

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic action_pkg::container_t alu_model(input action_pkg::container_t a,
            input action_pkg::container_t b, input action_pkg::sub_action_t act);
        action_pkg::container_t imm;
        imm = {24'd0, act[7:0]};
        case (act[15:13])
            action_pkg::OP_ADD:  return a + b;
            action_pkg::OP_SUB:  return a - b;
            action_pkg::OP_ADDI: return a + imm;
            action_pkg::OP_SET:  return imm;
            default:             return a;
        endcase
    endfunction

    // port is 7:0, drop flag is bit 8
    function automatic action_pkg::meta_t meta_model(input action_pkg::meta_t m,
            input action_pkg::sub_action_t act);
        action_pkg::meta_t r;
        r = m;
        case (act[15:13])
            action_pkg::MOP_SET_PORT: r[7:0] = act[7:0];
            action_pkg::MOP_DROP:     r[8] = 1'b1;
            action_pkg::MOP_ADD:      r = m + {24'd0, act[7:0]};
            default: ;
        endcase
        return r;
    endfunction

    // updates the model state array in acceptance order
    function automatic action_pkg::phv_t predict(input action_pkg::phv_t p,
            input action_pkg::action_t a);
        action_pkg::container_t  c [4];
        action_pkg::sub_action_t s [4];
        action_pkg::container_t  r3;
        action_pkg::container_t  old;
        logic [STATE_ADDR_W-1:0] idx;
        action_pkg::phv_t        e;
        for (int i = 0; i < 4; i++) begin
            c[i] = p[32*i+32 +: 32];
            s[i] = a[16*i+16 +: 16];
        end
        for (int i = 0; i < 3; i++) begin
            e[32*i+32 +: 32] = alu_model(c[s[i][12:11]], c[s[i][10:9]], s[i]);
        end
        idx = s[3][STATE_ADDR_W-1:0];
        r3  = c[s[3][12:11]];
        old = state_m[idx];
        case (s[3][15:13])
            action_pkg::OP_ST_ADD: begin
                state_m[idx] = old + r3;
                r3 = old + r3;
            end
            action_pkg::OP_ST_READ: r3 = old;
            action_pkg::OP_ST_WRITE: begin
                state_m[idx] = r3;
                r3 = old;
            end
            default: ;
        endcase
        e[159:128] = r3;
        e[31:0]    = meta_model(p[31:0], a[15:0]);
        return e;
    endfunction

    initial begin
        rst_seen     = 1'b0;
        first_acc    = 1'b0;
        stalled      = 1'b0;
        pending_o    = 0;
        data_errs_o  = 0;
        cfg_errs_o   = 0;
        proto_errs_o = 0;
    end

    // ======================================================================
    // comparison, sampled on the rising edge
    // ======================================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                state_m[i] = '0;
            end
            exp_q.delete();
            phase_q.delete();
            first_acc = 1'b0;
        end
        // idle values hold from reset until the first PHV
        if (rst_seen && !first_acc &&
                (out_valid_i !== 1'b0 || cfg_ack_i !== 1'b0 || dut_ready_i !== 1'b1)) begin
            $display("reset values wrong: phv_valid_o %b, cfg_ack_o %b, ready_o %b",
                     out_valid_i, cfg_ack_i, dut_ready_i);
            proto_errs_o++;
        end
        if (stalled && (out_valid_i !== 1'b1 || out_phv_i !== held_phv)) begin
            $display("phv_o or phv_valid_o changed while the output was stalled");
            proto_errs_o++;
        end
        if (rst_n && out_valid_i && ready_i) begin
            if (exp_q.size() == 0) begin
                $display("an output appeared with no accepted PHV waiting for it");
                proto_errs_o++;
            end else begin
                exp_phv   = exp_q.pop_front();
                exp_phase = phase_q.pop_front();
                for (int w = 0; w < 5; w++) begin
                    if (out_phv_i[32*w +: 32] !== exp_phv[32*w +: 32]) begin
                        $display("Error %s: word %0d (0 is metadata) expected %h actual %h",
                                 phase_name(exp_phase), w, exp_phv[32*w +: 32],
                                 out_phv_i[32*w +: 32]);
                        data_errs_o++;
                    end
                end
            end
        end
        if (rst_n && phv_valid_i && dut_ready_i) begin
            exp_q.push_back(predict(phv_i, action_i));
            phase_q.push_back(phase_i);
            first_acc = 1'b1;
        end
        // read data is the word before any write of the same access
        if (rst_n && cfg_ack_i) begin
            if (!cfg_req_i) begin
                $display("cfg_ack_o went high with no control request held");
                proto_errs_o++;
            end else begin
                if (cfg_rdata_i !== state_m[cfg_addr_i]) begin
                    $display("Error control: state word %0d expected %h actual %h",
                             cfg_addr_i, state_m[cfg_addr_i], cfg_rdata_i);
                    cfg_errs_o++;
                end
                if (cfg_we_i) begin
                    state_m[cfg_addr_i] = cfg_wdata_i;
                end
            end
        end
        stalled   = rst_n && out_valid_i && !ready_i;
        held_phv  = out_phv_i;
        pending_o = exp_q.size();
        if (!rst_n) begin
            rst_seen = 1'b1;
        end
    end

endmodule

//--- action_engine_tb.sv
`timescale 1ns/1ps

module action_engine_tb;

    localparam int          STATE_ADDR_W = 4;
    localparam logic [31:0] SEED         = 32'h8e0a_1804;
    localparam int N_STATELESS = 300;
    localparam int N_META      = 60;
    localparam int N_STATEFUL  = 100;
    localparam int N_BP        = 200;
    localparam int N_TRAFFIC   = 200;
    localparam int N_CFG       = 40;
    localparam int N_READBACK  = 8;
    localparam int N_OPS       = N_STATELESS + N_META + N_STATEFUL + N_BP + N_TRAFFIC
                                 + N_CFG + N_READBACK;
    localparam int CYCLE_LIMIT = 20 * N_OPS;

    // stimulus modes
    localparam int M_STATELESS = 0;
    localparam int M_META      = 1;
    localparam int M_STATEFUL  = 2;
    localparam int M_READBACK  = 3;

    logic                    clk;
    logic                    rst_n;
    action_pkg::phv_t        phv_i;
    action_pkg::action_t     action_i;
    logic                    phv_valid_i;
    logic                    ready_i;
    logic                    ready_o;
    action_pkg::phv_t        phv_o;
    logic                    phv_valid_o;
    logic                    cfg_req_i;
    logic                    cfg_we_i;
    logic [STATE_ADDR_W-1:0] cfg_addr_i;
    action_pkg::container_t  cfg_wdata_i;
    logic                    cfg_ack_o;
    action_pkg::container_t  cfg_rdata_o;

    logic [2:0]  phase;
    logic        bp_en;
    logic [31:0] data_st;
    logic [31:0] bp_st;
    logic [31:0] cfg_st;
    int          cycle_cnt;
    int          pending;
    int          data_errs;
    int          cfg_errs;
    int          proto_errs;

    action_engine #(.STATE_ADDR_W(STATE_ADDR_W)) dut_i (
        .clk(clk), .rst_n(rst_n),
        .phv_i(phv_i), .action_i(action_i), .phv_valid_i(phv_valid_i),
        .ready_i(ready_i), .ready_o(ready_o), .phv_o(phv_o), .phv_valid_o(phv_valid_o),
        .cfg_req_i(cfg_req_i), .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_ack_o(cfg_ack_o), .cfg_rdata_o(cfg_rdata_o)
    );

    action_engine_checker #(.STATE_ADDR_W(STATE_ADDR_W)) u_checker (
        .clk(clk), .rst_n(rst_n), .phase_i(phase),
        .phv_i(phv_i), .action_i(action_i), .phv_valid_i(phv_valid_i),
        .ready_i(ready_i), .dut_ready_i(ready_o), .out_phv_i(phv_o), .out_valid_i(phv_valid_o),
        .cfg_req_i(cfg_req_i), .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_ack_i(cfg_ack_o), .cfg_rdata_i(cfg_rdata_o),
        .pending_o(pending), .data_errs_o(data_errs), .cfg_errs_o(cfg_errs),
        .proto_errs_o(proto_errs)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // only the upper halves since the low LCG bits repeat quickly
    function automatic logic [31:0] next_word();
        logic [15:0] hi;
        data_st = lcg_step(data_st);
        hi      = data_st[31:16];
        data_st = lcg_step(data_st);
        return {hi, data_st[31:16]};
    endfunction

    // ======================================================================
    // stimulus tasks drive inputs on the falling edge
    // ======================================================================
    task automatic send_phv(input int mode, input int k);
        logic [31:0]             w;
        action_pkg::sub_action_t act [5];
        for (int i = 0; i < 5; i++) begin
            w = next_word();
            phv_i[32*i +: 32] = w;
            w = next_word();
            act[i] = w[15:0];
        end
        // slot 4 is container 3 and its data-path state indices stay in 0..7
        act[4][3] = 1'b0;
        w = next_word();
        if (mode == M_META) begin
            act[0][15:13] = action_pkg::MOP_SET_PORT + 3'(w[15:0] % 16'd3);
        end else if (mode == M_STATEFUL) begin
            act[4][15:13] = action_pkg::OP_ST_ADD + 3'(w[15:0] % 16'd3);
        end else if (mode == M_READBACK) begin
            act[4][15:13] = action_pkg::OP_ST_READ;
            act[4][7:0]   = 8'(8 + k);
        end
        action_i    = {act[4], act[3], act[2], act[1], act[0]};
        phv_valid_i = 1'b1;
        @(posedge clk);
        while (!ready_o) begin
            @(posedge clk);
        end
        @(negedge clk);
        phv_valid_i = 1'b0;
    endtask

    task automatic run_traffic(input int count);
        logic [31:0] w;
        for (int n = 0; n < count; n++) begin
            w = next_word();
            if (w[1:0] == 2'd0) begin
                @(negedge clk);
            end
            send_phv(M_STATELESS, n);
        end
    endtask

    task automatic cfg_access(input logic we, input logic [STATE_ADDR_W-1:0] addr,
                              input action_pkg::container_t wdata);
        cfg_req_i   = 1'b1;
        cfg_we_i    = we;
        cfg_addr_i  = addr;
        cfg_wdata_i = wdata;
        do begin
            @(negedge clk);
        end while (!cfg_ack_o);
        // request stays up until the ack pulse ends
        @(negedge clk);
        cfg_req_i = 1'b0;
    endtask

    // control port only touches words 8 to 15
    task automatic run_control();
        logic [31:0] w;
        for (int n = 0; n < N_CFG; n++) begin
            cfg_st = lcg_step(cfg_st);
            w      = cfg_st;
            cfg_st = lcg_step(cfg_st);
            cfg_access((w[31:24] % 8'd10) < 8'd6, 4'd8 + {1'b0, w[18:16]},
                       {w[31:16], cfg_st[31:16]});
            repeat (w[21:20]) @(negedge clk);
        end
    endtask

    task automatic print_counts();
        $display("errors: data %0d, control %0d, protocol %0d", data_errs, cfg_errs,
                 proto_errs);
    endtask

    // downstream stall about 30 percent of cycles
    always @(negedge clk) begin
        if (bp_en) begin
            bp_st   = lcg_step(bp_st);
            ready_i = (bp_st[31:16] % 16'd100) >= 16'd30;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", CYCLE_LIMIT);
        print_counts();
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        phv_i       = '0;
        action_i    = '0;
        phv_valid_i = 1'b0;
        ready_i     = 1'b0;
        cfg_req_i   = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        bp_en       = 1'b0;
        phase       = 3'd1;
        data_st     = SEED;
        bp_st       = SEED ^ 32'h0000_ffff;
        cfg_st      = SEED ^ 32'hffff_0000;
        rst_n       = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);
        ready_i = 1'b1;

        phase = 3'd2;
        for (int n = 0; n < N_STATELESS; n++) begin
            send_phv(M_STATELESS, n);
        end
        phase = 3'd3;
        for (int n = 0; n < N_META; n++) begin
            send_phv(M_META, n);
        end
        phase = 3'd4;
        for (int n = 0; n < N_STATEFUL; n++) begin
            send_phv(M_STATEFUL, n);
        end

        phase = 3'd5;
        bp_en = 1'b1;
        run_traffic(N_BP);

        phase = 3'd6;
        fork
            run_traffic(N_TRAFFIC);
            run_control();
        join
        bp_en = 1'b0;
        @(negedge clk);
        ready_i = 1'b1;
        // data-path reads of the words the control port wrote
        for (int k = 0; k < N_READBACK; k++) begin
            send_phv(M_READBACK, k);
        end
        while (pending != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        print_counts();
        if (data_errs + cfg_errs + proto_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- action_pkg.sv
package action_pkg;

    // ======================================================================
    // data widths
    // ======================================================================
    typedef logic [31:0]  container_t;
    typedef logic [31:0]  meta_t;
    typedef logic [159:0] phv_t;
    typedef logic [15:0]  sub_action_t;
    typedef logic [79:0]  action_t;

    // sub-action fields
    typedef logic [2:0] opcode_t;
    typedef logic [1:0] src_sel_t;
    typedef logic [7:0] imm_t;

    // stateless container opcodes
    localparam opcode_t OP_NOP  = 3'd0;
    localparam opcode_t OP_ADD  = 3'd1;
    localparam opcode_t OP_SUB  = 3'd2;
    localparam opcode_t OP_ADDI = 3'd3;
    localparam opcode_t OP_SET  = 3'd4;

    // stateful opcodes, container 3 only
    localparam opcode_t OP_ST_ADD   = 3'd5;
    localparam opcode_t OP_ST_READ  = 3'd6;
    localparam opcode_t OP_ST_WRITE = 3'd7;

    // metadata opcodes
    localparam opcode_t MOP_NOP      = 3'd0;
    localparam opcode_t MOP_SET_PORT = 3'd1;
    localparam opcode_t MOP_DROP     = 3'd2;
    localparam opcode_t MOP_ADD      = 3'd3;

    typedef enum logic {
        ARB_IDLE,
        ARB_ACK
    } arb_state_e;

    // layout: opcode 15:13, src a 12:11, src b 10:9, spare 8, imm 7:0
    function automatic opcode_t sub_opcode(input sub_action_t act);
        return act[15:13];
    endfunction

    function automatic src_sel_t sub_src_a(input sub_action_t act);
        return act[12:11];
    endfunction

    function automatic src_sel_t sub_src_b(input sub_action_t act);
        return act[10:9];
    endfunction

    function automatic imm_t sub_imm(input sub_action_t act);
        return act[7:0];
    endfunction

endpackage

//--- build.f
action_pkg.sv
action_crossbar.sv
container_alu.sv
stateful_alu.sv
metadata_alu.sv
state_mem_arbiter.sv
action_engine.sv
action_engine_checker.sv
action_engine_tb.sv

//--- container_alu.sv
`timescale 1ns/1ps

module container_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    adv_i,
    input  action_pkg::container_t  op_a_i,
    input  action_pkg::container_t  op_b_i,
    input  action_pkg::sub_action_t sub_act_i,
    output action_pkg::container_t  result_o
);

    action_pkg::opcode_t    opcode;
    action_pkg::container_t imm_ext;
    action_pkg::container_t result_d;
    action_pkg::container_t result_q;

    assign opcode  = action_pkg::sub_opcode(sub_act_i);
    assign imm_ext = {24'd0, action_pkg::sub_imm(sub_act_i)};

    always_comb begin
        case (opcode)
            action_pkg::OP_NOP:  result_d = op_a_i;
            action_pkg::OP_ADD:  result_d = op_a_i + op_b_i;
            action_pkg::OP_SUB:  result_d = op_a_i - op_b_i;
            action_pkg::OP_ADDI: result_d = op_a_i + imm_ext;
            action_pkg::OP_SET:  result_d = imm_ext;
            // stateful codes mean nothing here
            default:             result_d = op_a_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q <= '0;
        end else if (adv_i) begin
            result_q <= result_d;
        end
    end

    assign result_o = result_q;

endmodule

//--- metadata_alu.sv
`timescale 1ns/1ps

module metadata_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    adv_i,
    input  action_pkg::meta_t       meta_i,
    input  action_pkg::sub_action_t meta_act_i,
    output action_pkg::meta_t       meta_o
);

    action_pkg::imm_t  imm;
    action_pkg::meta_t meta_d;
    action_pkg::meta_t meta_q;

    assign imm = action_pkg::sub_imm(meta_act_i);

    // port in 7:0, drop flag in bit 8
    always_comb begin
        meta_d = meta_i;
        case (action_pkg::sub_opcode(meta_act_i))
            action_pkg::MOP_NOP:      meta_d = meta_i;
            action_pkg::MOP_SET_PORT: meta_d[7:0] = imm;
            action_pkg::MOP_DROP:     meta_d[8] = 1'b1;
            action_pkg::MOP_ADD:      meta_d = meta_i + {24'd0, imm};
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            meta_q <= '0;
        end else if (adv_i) begin
            meta_q <= meta_d;
        end
    end

    assign meta_o = meta_q;

endmodule

//--- state_mem_arbiter.sv
`timescale 1ns/1ps

module state_mem_arbiter #(
    parameter int STATE_ADDR_W = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [STATE_ADDR_W-1:0] st_addr_i,
    input  action_pkg::container_t  st_wdata_i,
    input  logic                    st_we_i,
    output action_pkg::container_t  st_rdata_o,
    input  logic                    cfg_req_i,
    input  logic                    cfg_we_i,
    input  logic [STATE_ADDR_W-1:0] cfg_addr_i,
    input  action_pkg::container_t  cfg_wdata_i,
    output logic                    cfg_ack_o,
    output action_pkg::container_t  cfg_rdata_o
);

    localparam int DEPTH = 2 ** STATE_ADDR_W;

    action_pkg::container_t mem [DEPTH];
    action_pkg::container_t cfg_rdata_q;
    action_pkg::arb_state_e state_q;
    logic                   grant;

    // data path always wins, control waits for a cycle without a write
    assign grant = (state_q == action_pkg::ARB_IDLE) & cfg_req_i & ~st_we_i;

    assign st_rdata_o = mem[st_addr_i];

    // ======================================================================
    // state words
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (st_we_i) begin
            mem[st_addr_i] <= st_wdata_i;
        end else if (grant && cfg_we_i) begin
            mem[cfg_addr_i] <= cfg_wdata_i;
        end
    end

    // ack one cycle after grant, then back to idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= action_pkg::ARB_IDLE;
        end else if (grant) begin
            state_q <= action_pkg::ARB_ACK;
        end else begin
            state_q <= action_pkg::ARB_IDLE;
        end
    end

    // old word, captured before the write lands
    always_ff @(posedge clk) begin
        if (grant) begin
            cfg_rdata_q <= mem[cfg_addr_i];
        end
    end

    assign cfg_ack_o   = (state_q == action_pkg::ARB_ACK);
    assign cfg_rdata_o = cfg_rdata_q;

endmodule

//--- stateful_alu.sv
`timescale 1ns/1ps

module stateful_alu #(
    parameter int STATE_ADDR_W = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    adv_i,
    input  logic                    valid_i,
    input  action_pkg::container_t  op_a_i,
    input  action_pkg::sub_action_t sub_act_i,
    input  action_pkg::container_t  st_rdata_i,
    output action_pkg::container_t  result_o,
    output logic                    valid_o,
    output logic [STATE_ADDR_W-1:0] st_addr_o,
    output action_pkg::container_t  st_wdata_o,
    output logic                    st_we_o
);

    action_pkg::opcode_t    opcode;
    action_pkg::container_t new_state;
    action_pkg::container_t result_d;
    action_pkg::container_t result_q;
    logic                   is_write;
    logic                   valid_q;

    assign opcode    = action_pkg::sub_opcode(sub_act_i);
    // state index from the low immediate bits
    assign st_addr_o = action_pkg::sub_imm(sub_act_i)[STATE_ADDR_W-1:0];

    always_comb begin
        new_state = st_rdata_i;
        result_d  = op_a_i;
        is_write  = 1'b0;
        case (opcode)
            action_pkg::OP_ST_ADD: begin
                new_state = st_rdata_i + op_a_i;
                result_d  = new_state;
                is_write  = 1'b1;
            end
            action_pkg::OP_ST_READ: begin
                result_d = st_rdata_i;
            end
            action_pkg::OP_ST_WRITE: begin
                new_state = op_a_i;
                result_d  = st_rdata_i;
                is_write  = 1'b1;
            end
            default: ;
        endcase
    end

    // only on an advancing edge, so a stalled item writes once
    assign st_we_o    = is_write & valid_i & adv_i;
    assign st_wdata_o = new_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            result_q <= '0;
        end else if (adv_i) begin
            valid_q  <= valid_i;
            result_q <= result_d;
        end
    end

    assign valid_o  = valid_q;
    assign result_o = result_q;

endmodule
